/* mat_quant_top.f */
+incdir+tests
common/mq_pkg.sv
common/mreg_port_if.sv
common/qrow_stream_if.sv
source/matrix_reg.sv
load/row_loader.sv
quant/quant_ctrl.sv
quant/quant_row.sv
store/row_storer.sv
source/mat_quant_top.sv
tests/mat_quant_tb.sv

/* Bender.yml */
package:
  name: mat_quant

sources:
  # shared package and interfaces
  - common/mq_pkg.sv
  - common/mreg_port_if.sv
  - common/qrow_stream_if.sv
  # design
  - source/matrix_reg.sv
  - load/row_loader.sv
  - quant/quant_ctrl.sv
  - quant/quant_row.sv
  - store/row_storer.sv
  - source/mat_quant_top.sv
  # testbench
  - target: test
    include_dirs:
      - tests
    files:
      - tests/mat_quant_tb.sv

/* tests/quant_model.svh */
`ifndef QUANT_MODEL_SVH
`define QUANT_MODEL_SVH

// --------------------------------------------------
// reference model for the quantizer
// --------------------------------------------------

// largest unbiased exponent over elements with a nonzero exponent field
// all-zero matrix gives 0
function automatic exp_t model_exp_max(input fp32_t m [MAT_N][MAT_N]);
  int e;
  int best;
  bit found;
  best  = 0;
  found = 1'b0;
  for (int r = 0; r < MAT_N; r++) begin
    for (int c = 0; c < MAT_N; c++) begin
      if (m[r][c][30:23] != 8'h00) begin
        e = int'(m[r][c][30:23]) - 127;
        if (!found || e > best) begin
          best = e;
        end
        found = 1'b1;
      end
    end
  end
  return exp_t'(best);
endfunction

// shift = 17 + emax - e on the 24-bit mantissa, flush at 24 or more
function automatic qint_t model_quant(input fp32_t x, input exp_t emax);
  int e;
  int shift;
  int mag;
  // zero and subnormal
  if (x[30:23] == 8'h00) begin
    return '0;
  end
  e     = int'(x[30:23]) - 127;
  shift = 17 + int'(emax) - e;
  if (shift >= 24) begin
    mag = 0;
  end else begin
    mag = int'({1'b1, x[22:0]}) >> shift;
  end
  return x[31] ? qint_t'(-mag) : qint_t'(mag);
endfunction

// element c of output row r, column order when transposed
function automatic fp32_t model_pick(input fp32_t m [MAT_N][MAT_N], input int r, input int c,
                                     input bit tr);
  return tr ? m[c][r] : m[r][c];
endfunction

`endif

/* tests/mat_quant_tb.sv */
`timescale 1ns/1ps

module mat_quant_tb
  import mq_pkg::*;
;

  localparam int MAT_N      = 4;
  localparam int WAIT_LIMIT = 200;

  typedef enum logic [1:0] {MK_RANDOM, MK_ZERO, MK_MIXED, MK_WIDE} mat_kind_e;
  typedef enum logic {RDY_ALWAYS, RDY_RANDOM} rdy_mode_e;

  typedef struct packed {
    logic      transpose;
    mat_kind_e kind;
    rdy_mode_e rdy;
  } job_t;

  // one job per entry
  localparam job_t JOB_TBL [8] = '{
    '{1'b0, MK_RANDOM, RDY_ALWAYS},
    '{1'b1, MK_RANDOM, RDY_ALWAYS},
    '{1'b0, MK_ZERO,   RDY_ALWAYS},
    '{1'b0, MK_MIXED,  RDY_RANDOM},
    '{1'b1, MK_WIDE,   RDY_ALWAYS},
    '{1'b0, MK_WIDE,   RDY_RANDOM},
    '{1'b1, MK_MIXED,  RDY_RANDOM},
    '{1'b1, MK_RANDOM, RDY_RANDOM}
  };

  logic  clk = 1'b0;
  logic  rstnn;
  logic  cmd_valid_i;
  logic  cmd_transpose_i;
  logic  cmd_ready_o;
  logic  in_valid_i;
  logic  in_last_i;
  fp32_t in_row_i [MAT_N];
  logic  in_ready_o;
  logic  out_valid_o;
  logic  out_last_o;
  qint_t out_row_o [MAT_N];
  logic  out_ready_i;
  exp_t  scale_exp_o;
  logic  done_o;

  // matrix of the current job
  fp32_t mat [MAT_N][MAT_N];

  `include "quant_model.svh"

  mat_quant_top #(.MAT_N(MAT_N)) mat_quant_top_inst (
    .clk             (clk),
    .rstnn           (rstnn),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_transpose_i (cmd_transpose_i),
    .cmd_ready_o     (cmd_ready_o),
    .in_valid_i      (in_valid_i),
    .in_last_i       (in_last_i),
    .in_row_i        (in_row_i),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .out_last_o      (out_last_o),
    .out_row_o       (out_row_o),
    .out_ready_i     (out_ready_i),
    .scale_exp_o     (scale_exp_o),
    .done_o          (done_o)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_qint(input qint_t got, input qint_t expect_v, input string what);
    if (got !== expect_v) begin
      abort_run($sformatf("Error at %0t: %s, got %0d expected %0d", $time, what, got,
                          expect_v));
    end
  endtask

  task automatic check_exp(input exp_t got, input exp_t expect_v, input string what);
    if (got !== expect_v) begin
      abort_run($sformatf("Error at %0t: %s, got %0d expected %0d", $time, what, got,
                          expect_v));
    end
  endtask

  task automatic check_last(input logic got, input logic expect_v, input int row);
    if (got !== expect_v) begin
      abort_run($sformatf("Error at %0t: out_last_o on row %0d, got %b expected %b", $time,
                          row, got, expect_v));
    end
  endtask

  // control levels
  task automatic check_flag(input logic got, input logic expect_v, input string what);
    if (got !== expect_v) begin
      abort_run($sformatf("Error at %0t: %s, got %b expected %b", $time, what, got,
                          expect_v));
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  // sign, exponent field, mantissa per matrix kind
  task automatic build_matrix(input mat_kind_e kind);
    for (int r = 0; r < MAT_N; r++) begin
      for (int c = 0; c < MAT_N; c++) begin
        case (kind)
          MK_ZERO:  mat[r][c] = ((r + c) % 2 != 0) ? 32'h8000_0000 : 32'h0;
          MK_MIXED: mat[r][c] = {1'((r + c) % 2), 8'($urandom_range(124, 130)),
                                 23'($urandom)};
          MK_WIDE:  mat[r][c] = {1'($urandom_range(0, 1)), 8'($urandom_range(100, 150)),
                                 23'($urandom)};
          default:  mat[r][c] = {1'($urandom_range(0, 1)), 8'($urandom_range(110, 140)),
                                 23'($urandom)};
        endcase
      end
    end
    // one subnormal that counts as zero
    if (kind == MK_WIDE) begin
      mat[1][2] = {1'b1, 8'h00, 23'($urandom) | 23'h1};
    end
  endtask

  function automatic logic next_ready(input rdy_mode_e rdy);
    return (rdy == RDY_ALWAYS) ? 1'b1 : 1'($urandom_range(0, 1));
  endfunction

  task automatic send_command(input logic tr);
    int waited;
    waited = 0;
    cmd_valid_i     <= 1'b1;
    cmd_transpose_i <= tr;
    do begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("timed out waiting for cmd_ready_o");
      end
    end while (!cmd_ready_o);
    cmd_valid_i <= 1'b0;
  endtask

  task automatic send_rows();
    int waited;
    for (int r = 0; r < MAT_N; r++) begin
      waited = 0;
      in_valid_i <= 1'b1;
      in_last_i  <= (r == MAT_N - 1);
      for (int c = 0; c < MAT_N; c++) begin
        in_row_i[c] <= mat[r][c];
      end
      do begin
        @(posedge clk);
        check_flag(cmd_ready_o, 1'b0, "cmd_ready_o while loading");
        waited++;
        if (waited > WAIT_LIMIT) begin
          abort_run($sformatf("timed out waiting for in_ready_o on row %0d", r));
        end
      end while (!in_ready_o);
    end
    in_valid_i <= 1'b0;
    in_last_i  <= 1'b0;
  endtask

  // values sampled before the edge updates are the transfer values
  task automatic collect_job(input logic tr, input rdy_mode_e rdy, input exp_t emax);
    int    row_idx;
    int    waited;
    bit    held;
    qint_t held_row [MAT_N];
    qint_t expect_q;
    row_idx = 0;
    waited  = 0;
    held    = 1'b0;
    out_ready_i <= next_ready(rdy);
    while (row_idx < MAT_N) begin
      @(posedge clk);
      check_flag(cmd_ready_o, 1'b0, "cmd_ready_o during readback");
      check_flag(done_o, 1'b0, "done_o before the last row");
      // stalled row must stay put
      if (held) begin
        check_flag(out_valid_o, 1'b1, "out_valid_o dropped while stalled");
        for (int c = 0; c < MAT_N; c++) begin
          check_qint(out_row_o[c], held_row[c], "row changed while stalled");
        end
      end
      held = 1'b0;
      if (out_valid_o && out_ready_i) begin
        for (int c = 0; c < MAT_N; c++) begin
          expect_q = model_quant(model_pick(mat, row_idx, c, tr), emax);
          check_qint(out_row_o[c], expect_q, $sformatf("row %0d element %0d", row_idx, c));
        end
        check_last(out_last_o, row_idx == MAT_N - 1, row_idx);
        row_idx++;
        waited = 0;
      end else if (out_valid_o) begin
        held     = 1'b1;
        held_row = out_row_o;
      end
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run($sformatf("timed out waiting for output row %0d", row_idx));
      end
      out_ready_i <= next_ready(rdy);
    end
    // done one cycle after the last transfer while the scale is still held
    @(posedge clk);
    check_flag(done_o, 1'b1, "done_o after the last row");
    check_flag(cmd_ready_o, 1'b1, "cmd_ready_o with done_o");
    check_exp(scale_exp_o, emax, "scale_exp_o");
    @(posedge clk);
    check_flag(done_o, 1'b0, "done_o longer than one cycle");
    check_flag(out_valid_o, 1'b0, "out_valid_o after the job");
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    exp_t emax;
    void'($urandom(32'h3d40));
    rstnn           <= 1'b0;
    cmd_valid_i     <= 1'b0;
    cmd_transpose_i <= 1'b0;
    in_valid_i      <= 1'b0;
    in_last_i       <= 1'b0;
    out_ready_i     <= 1'b1;
    for (int c = 0; c < MAT_N; c++) begin
      in_row_i[c] <= '0;
    end
    repeat (3) @(posedge clk);
    check_flag(out_valid_o, 1'b0, "out_valid_o in reset");
    check_flag(out_last_o, 1'b0, "out_last_o in reset");
    check_flag(done_o, 1'b0, "done_o in reset");
    check_flag(cmd_ready_o, 1'b0, "cmd_ready_o in reset");
    check_flag(in_ready_o, 1'b0, "in_ready_o in reset");
    rstnn <= 1'b1;
    // cmd_ready rises on the first edge out of reset
    repeat (2) @(posedge clk);
    check_flag(cmd_ready_o, 1'b1, "cmd_ready_o after reset");
    check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
    check_flag(out_last_o, 1'b0, "out_last_o after reset");
    check_flag(done_o, 1'b0, "done_o after reset");
    for (int j = 0; j < $size(JOB_TBL); j++) begin
      build_matrix(JOB_TBL[j].kind);
      emax = model_exp_max(mat);
      send_command(JOB_TBL[j].transpose);
      send_rows();
      collect_job(JOB_TBL[j].transpose, JOB_TBL[j].rdy, emax);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

/* source/mat_quant_top.sv */
`timescale 1ns/1ps

module mat_quant_top
  import mq_pkg::*;
#(
  parameter int MAT_N = 4
) (
  input  logic  clk,
  input  logic  rstnn,
  // command
  input  logic  cmd_valid_i,
  input  logic  cmd_transpose_i,
  output logic  cmd_ready_o,
  // input rows
  input  logic  in_valid_i,
  input  logic  in_last_i,
  input  fp32_t in_row_i [MAT_N],
  output logic  in_ready_o,
  // output rows
  output logic  out_valid_o,
  output logic  out_last_o,
  output qint_t out_row_o [MAT_N],
  input  logic  out_ready_i,
  // status
  output exp_t  scale_exp_o,
  output logic  done_o
);

  // loader to controller
  logic load_done;
  exp_t exp_max_ld;
  // controller to loader, mreg and quantizer
  logic load_enable;
  logic transpose;
  exp_t exp_max_q;
  // read issue handshake
  logic adv;
  logic rd_valid;
  // storer back to controller
  logic last_row_done;

  mreg_port_if #(.MAT_N(MAT_N)) mreg_if ();
  qrow_stream_if #(.MAT_N(MAT_N)) qrow_if ();

  // --------------------------------------------------
  // load side
  // --------------------------------------------------

  row_loader #(.MAT_N(MAT_N)) row_loader_inst (
    .clk           (clk),
    .rstnn         (rstnn),
    .load_enable_i (load_enable),
    .in_valid_i    (in_valid_i),
    .in_last_i     (in_last_i),
    .in_row_i      (in_row_i),
    .in_ready_o    (in_ready_o),
    .load_done_o   (load_done),
    .exp_max_o     (exp_max_ld),
    .mreg          (mreg_if.loader)
  );

  // --------------------------------------------------
  // processing
  // --------------------------------------------------

  matrix_reg #(.MAT_N(MAT_N)) matrix_reg_inst (
    .clk         (clk),
    .rstnn       (rstnn),
    .transpose_i (transpose),
    .port        (mreg_if.mreg)
  );

  quant_ctrl #(.MAT_N(MAT_N)) quant_ctrl_inst (
    .clk             (clk),
    .rstnn           (rstnn),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_transpose_i (cmd_transpose_i),
    .cmd_ready_o     (cmd_ready_o),
    .load_done_i     (load_done),
    .exp_max_i       (exp_max_ld),
    .load_enable_o   (load_enable),
    .transpose_o     (transpose),
    .exp_max_o       (exp_max_q),
    .adv_i           (adv),
    .rd_valid_o      (rd_valid),
    .last_row_done_i (last_row_done),
    .scale_exp_o     (scale_exp_o),
    .done_o          (done_o),
    .rd              (mreg_if.reader)
  );

  quant_row #(.MAT_N(MAT_N)) quant_row_inst (
    .clk        (clk),
    .rstnn      (rstnn),
    .rd_valid_i (rd_valid),
    .rdata_i    (mreg_if.rdata),
    .exp_max_i  (exp_max_q),
    .adv_o      (adv),
    .out        (qrow_if.src)
  );

  // --------------------------------------------------
  // store side
  // --------------------------------------------------

  row_storer #(.MAT_N(MAT_N)) row_storer_inst (
    .clk             (clk),
    .rstnn           (rstnn),
    .in              (qrow_if.dst),
    .out_valid_o     (out_valid_o),
    .out_last_o      (out_last_o),
    .out_row_o       (out_row_o),
    .out_ready_i     (out_ready_i),
    .last_row_done_o (last_row_done)
  );

endmodule

/* store/row_storer.sv */
`timescale 1ns/1ps

module row_storer
  import mq_pkg::*;
#(
  parameter int MAT_N = 4
) (
  input  logic  clk,
  input  logic  rstnn,
  qrow_stream_if.dst in,
  output logic  out_valid_o,
  output logic  out_last_o,
  output qint_t out_row_o [MAT_N],
  input  logic  out_ready_i,
  output logic  last_row_done_o
);

  localparam int AW = (MAT_N > 1) ? $clog2(MAT_N) : 1;

  logic          in_fire;
  logic          out_fire;
  // rows already sent in this job
  logic [AW-1:0] out_cnt;

  // register empty or emptying this cycle
  assign in.ready = !out_valid_o || out_ready_i;
  assign in_fire  = in.valid && in.ready;
  assign out_fire = out_valid_o && out_ready_i;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      out_valid_o <= 1'b0;
      out_cnt     <= '0;
    end else begin
      if (in_fire) begin
        out_valid_o <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_o <= 1'b0;
      end
      // wraps after the last row
      if (out_fire) begin
        out_cnt <= out_last_o ? '0 : out_cnt + 1'b1;
      end
    end
  end

  // output row register
  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_row_o <= in.row;
    end
  end

  assign out_last_o      = out_valid_o && (out_cnt == AW'(MAT_N - 1));
  // end of job seen by the controller
  assign last_row_done_o = out_fire && out_last_o;

  // held row must not change under back-pressure
  for (genvar c = 0; c < MAT_N; c++) begin : g_hold
    row_hold_a : assert property (
      @(posedge clk) disable iff (!rstnn)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_row_o[c]))
    ) else $error("output element %0d changed while stalled", c);
  end

endmodule

/* quant/quant_row.sv */
`timescale 1ns/1ps

module quant_row
  import mq_pkg::*;
#(
  parameter int MAT_N = 4
) (
  input  logic  clk,
  input  logic  rstnn,
  input  logic  rd_valid_i,
  input  fp32_t rdata_i [MAT_N],
  input  exp_t  exp_max_i,
  output logic  adv_o,
  qrow_stream_if.src out
);

  // top mantissa bit of the largest exponent lands on Q_TOP_BIT
  localparam int SHIFT_BASE  = FP_MANT_W - Q_TOP_BIT;
  // shifting the full 24-bit mantissa out gives zero
  localparam int FLUSH_SHIFT = FP_MANT_W + 1;
  localparam int SW          = $clog2(FLUSH_SHIFT);

  // occupancy of mreg output, stage 1, stage 2
  logic data_v;
  logic s1_v;
  logic s2_v;
  logic s1_ld;
  logic s2_ld;

  // stage 1 inputs
  int               shift_full [MAT_N];
  logic             flush_d    [MAT_N];
  // stage 1 registers
  logic [FP_MANT_W:0] s1_mant  [MAT_N];
  logic [SW-1:0]      s1_shift [MAT_N];
  logic               s1_sign  [MAT_N];
  logic               s1_flush [MAT_N];
  // stage 2 inputs
  logic [FP_MANT_W:0] mag      [MAT_N];
  qint_t              q_d      [MAT_N];

  // --------------------------------------------------
  // flow control
  // --------------------------------------------------

  assign s2_ld = !s2_v || out.ready;
  assign s1_ld = !s1_v || s2_ld;
  // read data slot is free, or drains into stage 1 this cycle
  assign adv_o = !data_v || s1_ld;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      data_v <= 1'b0;
      s1_v   <= 1'b0;
      s2_v   <= 1'b0;
    end else begin
      if (rd_valid_i) begin
        data_v <= 1'b1;
      end else if (s1_ld) begin
        data_v <= 1'b0;
      end
      if (s1_ld) begin
        s1_v <= data_v;
      end
      if (s2_ld) begin
        s2_v <= s1_v;
      end
    end
  end

  // --------------------------------------------------
  // stage 1, shift amount per element
  // --------------------------------------------------

  // shift = base + emax - e, e unbiased
  always_comb begin
    for (int c = 0; c < MAT_N; c++) begin
      shift_full[c] = SHIFT_BASE + int'(exp_max_i)
                    - (int'(rdata_i[c][FP_MANT_W +: FP_EXP_W]) - FP_EXP_BIAS);
      flush_d[c]    = (rdata_i[c][FP_MANT_W +: FP_EXP_W] == '0)
                    || (shift_full[c] >= FLUSH_SHIFT);
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ld && data_v) begin
      for (int c = 0; c < MAT_N; c++) begin
        // hidden one restored
        s1_mant[c]  <= {1'b1, rdata_i[c][FP_MANT_W-1:0]};
        s1_shift[c] <= SW'(shift_full[c]);
        s1_sign[c]  <= rdata_i[c][FP_EXP_W + FP_MANT_W];
        s1_flush[c] <= flush_d[c];
      end
    end
  end

  // --------------------------------------------------
  // stage 2, shift, sign, saturate-free pack
  // --------------------------------------------------

  // magnitude is at most 127 here, so the low Q_BITS hold it exactly
  always_comb begin
    for (int c = 0; c < MAT_N; c++) begin
      mag[c] = s1_mant[c] >> s1_shift[c];
      if (s1_flush[c]) begin
        q_d[c] = '0;
      end else if (s1_sign[c]) begin
        q_d[c] = -qint_t'(mag[c][Q_BITS-1:0]);
      end else begin
        q_d[c] = qint_t'(mag[c][Q_BITS-1:0]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s2_ld && s1_v) begin
      out.row <= q_d;
    end
  end

  assign out.valid = s2_v;

endmodule

/* quant/quant_ctrl.sv */
`timescale 1ns/1ps

module quant_ctrl
  import mq_pkg::*;
#(
  parameter int MAT_N = 4
) (
  input  logic clk,
  input  logic rstnn,
  input  logic cmd_valid_i,
  input  logic cmd_transpose_i,
  output logic cmd_ready_o,
  input  logic load_done_i,
  input  exp_t exp_max_i,
  output logic load_enable_o,
  output logic transpose_o,
  output exp_t exp_max_o,
  input  logic adv_i,
  output logic rd_valid_o,
  input  logic last_row_done_i,
  output exp_t scale_exp_o,
  output logic done_o,
  mreg_port_if.reader rd
);

  localparam int AW = (MAT_N > 1) ? $clog2(MAT_N) : 1;
  localparam int CW = $clog2(MAT_N + 1);

  ctrl_state_e   state_q;
  ctrl_state_e   state_d;
  logic          cmd_fire;
  logic          issue;
  logic [CW-1:0] rd_cnt;
  exp_t          exp_q;

  assign cmd_fire = cmd_valid_i && cmd_ready_o;

  // --------------------------------------------------
  // job FSM
  // --------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (cmd_fire) state_d = LOAD;
      LOAD: if (load_done_i) state_d = EXEC;
      EXEC: if (last_row_done_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // cmd_ready registered off the next state
  // low during reset, high from the first edge in IDLE
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      state_q     <= IDLE;
      cmd_ready_o <= 1'b0;
      done_o      <= 1'b0;
      transpose_o <= 1'b0;
      exp_q       <= '0;
    end else begin
      state_q     <= state_d;
      cmd_ready_o <= (state_d == IDLE);
      // pulse in the cycle after the final output transfer
      done_o      <= (state_q == EXEC) && last_row_done_i;
      if (cmd_fire) begin
        transpose_o <= cmd_transpose_i;
      end
      // scale frozen for the whole EXEC phase and after
      if (state_q == LOAD && load_done_i) begin
        exp_q <= exp_max_i;
      end
    end
  end

  assign load_enable_o = (state_q == LOAD);
  assign exp_max_o     = exp_q;
  assign scale_exp_o   = exp_q;

  // --------------------------------------------------
  // read sequencing
  // --------------------------------------------------

  // one row per cycle while rows remain and the quantizer front can take it
  assign issue      = (rd_cnt < CW'(MAT_N)) && adv_i;
  assign rd.ren     = issue;
  assign rd.raddr   = rd_cnt[AW-1:0];
  assign rd_valid_o = issue;

  // counter rests at MAT_N when no job is reading
  // armed with row 0 on entry to EXEC
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      rd_cnt <= CW'(MAT_N);
    end else if (state_q == LOAD && load_done_i) begin
      rd_cnt <= '0;
    end else if (issue) begin
      rd_cnt <= rd_cnt + 1'b1;
    end
  end

  // counter only armed while the FSM sits in EXEC
  read_in_exec_a : assert property (
    @(posedge clk) disable iff (!rstnn)
    rd.ren |-> (state_q == EXEC)
  ) else $error("matrix read issued outside EXEC");

  // storer only finishes once every row has been read out
  all_read_at_end_a : assert property (
    @(posedge clk) disable iff (!rstnn)
    last_row_done_i |-> (state_q == EXEC && rd_cnt == CW'(MAT_N))
  ) else $error("last row stored before all reads were issued");

endmodule

/* load/row_loader.sv */
`timescale 1ns/1ps

module row_loader
  import mq_pkg::*;
#(
  parameter int MAT_N = 4
) (
  input  logic  clk,
  input  logic  rstnn,
  input  logic  load_enable_i,
  input  logic  in_valid_i,
  input  logic  in_last_i,
  input  fp32_t in_row_i [MAT_N],
  output logic  in_ready_o,
  output logic  load_done_o,
  output exp_t  exp_max_o,
  mreg_port_if.loader mreg
);

  localparam int AW = (MAT_N > 1) ? $clog2(MAT_N) : 1;

  logic          fire;
  logic          last_row;
  logic [AW-1:0] row_cnt;
  // per element unbiased exponent
  exp_t          elem_exp [MAT_N];
  // largest exponent of the current row, and whether any element counts
  exp_t          row_max;
  logic          row_any;
  // running maximum over the job
  exp_t          emax_q;
  logic          any_q;

  // stop taking rows in the gap before the controller leaves LOAD
  assign in_ready_o = load_enable_i && !load_done_o;
  assign fire       = in_valid_i && in_ready_o;
  assign last_row   = (row_cnt == AW'(MAT_N - 1));

  // row goes straight into the matrix register
  assign mreg.wen   = fire;
  assign mreg.waddr = row_cnt;
  assign mreg.wdata = in_row_i;

  always_comb begin
    for (int c = 0; c < MAT_N; c++) begin
      elem_exp[c] = exp_t'(int'(in_row_i[c][FP_MANT_W +: FP_EXP_W]) - FP_EXP_BIAS);
    end
  end

  // zero exponent field means zero or subnormal, skipped
  always_comb begin
    row_max = '0;
    row_any = 1'b0;
    for (int c = 0; c < MAT_N; c++) begin
      if (in_row_i[c][FP_MANT_W +: FP_EXP_W] != '0) begin
        if (!row_any || elem_exp[c] > row_max) begin
          row_max = elem_exp[c];
        end
        row_any = 1'b1;
      end
    end
  end

  // row counter wraps after the last row, so each job starts at row 0
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      row_cnt     <= '0;
      load_done_o <= 1'b0;
      emax_q      <= '0;
      any_q       <= 1'b0;
    end else begin
      load_done_o <= fire && last_row;
      if (fire) begin
        row_cnt <= last_row ? '0 : row_cnt + 1'b1;
        // first row restarts the maximum
        if (row_cnt == '0) begin
          emax_q <= row_max;
          any_q  <= row_any;
        end else begin
          if (row_any && (!any_q || row_max > emax_q)) begin
            emax_q <= row_max;
          end
          any_q <= any_q || row_any;
        end
      end
    end
  end

  // all-zero matrix reports exponent zero
  assign exp_max_o = any_q ? emax_q : '0;

  // source marks the final row of the matrix
  last_flag_a : assert property (
    @(posedge clk) disable iff (!rstnn)
    fire |-> (in_last_i == last_row)
  ) else $error("in_last_i not aligned with row %0d of the matrix", MAT_N);

endmodule

/* source/matrix_reg.sv */
`timescale 1ns/1ps

module matrix_reg
  import mq_pkg::*;
#(
  parameter int MAT_N = 4
) (
  input  logic clk,
  input  logic rstnn,
  input  logic transpose_i,
  mreg_port_if.mreg port
);

  // element storage, mem[row][col]
  fp32_t mem [MAT_N][MAT_N];

  // whole row written at once
  always_ff @(posedge clk) begin
    if (port.wen) begin
      mem[port.waddr] <= port.wdata;
    end
  end

  // registered read
  // transpose picks column raddr instead of row raddr
  always_ff @(posedge clk) begin
    if (port.ren) begin
      for (int c = 0; c < MAT_N; c++) begin
        if (transpose_i) begin
          port.rdata[c] <= mem[c][port.raddr];
        end else begin
          port.rdata[c] <= mem[port.raddr][c];
        end
      end
    end
  end

  // loading and readback never overlap, they belong to different job phases
  no_rw_overlap_a : assert property (
    @(posedge clk) disable iff (!rstnn)
    !(port.wen && port.ren)
  ) else $error("matrix register read and write in the same cycle");

endmodule

/* common/qrow_stream_if.sv */
`timescale 1ns/1ps

interface qrow_stream_if
  import mq_pkg::*;
#(
  parameter int MAT_N = 4
);

  // quantized row, transfer on valid and ready both high
  logic  valid;
  logic  ready;
  qint_t row [MAT_N];

  // producer side
  modport src (
    output valid,
    output row,
    input  ready
  );

  // consumer side
  modport dst (
    input  valid,
    input  row,
    output ready
  );

endinterface

/* common/mreg_port_if.sv */
`timescale 1ns/1ps

interface mreg_port_if
  import mq_pkg::*;
#(
  parameter int MAT_N = 4
);

  localparam int AW = (MAT_N > 1) ? $clog2(MAT_N) : 1;

  // row write side
  logic          wen;
  logic [AW-1:0] waddr;
  fp32_t         wdata [MAT_N];

  // row or column read side, data one cycle after ren
  logic          ren;
  logic [AW-1:0] raddr;
  fp32_t         rdata [MAT_N];

  modport loader (output wen, output waddr, output wdata);

  modport reader (output ren, output raddr);

  modport mreg (
    input  wen,
    input  waddr,
    input  wdata,
    input  ren,
    input  raddr,
    output rdata
  );

endinterface

/* common/mq_pkg.sv */
package mq_pkg;

  // --------------------------------------------------
  // ieee-754 single precision fields
  // --------------------------------------------------

  // exponent field width
  parameter int FP_EXP_W = 8;
  // mantissa field width, hidden one not counted
  parameter int FP_MANT_W = 23;
  // exponent bias
  parameter int FP_EXP_BIAS = 127;

  // --------------------------------------------------
  // quantized format
  // --------------------------------------------------

  // width of one quantized element
  parameter int Q_BITS = 8;
  // bit position the largest exponent lands on
  parameter int Q_TOP_BIT = 6;

  // one input element, raw fp32 bits
  typedef logic [31:0] fp32_t;

  // one quantized element
  typedef logic signed [Q_BITS-1:0] qint_t;

  // unbiased exponent, wide enough for -127..128 plus headroom
  typedef logic signed [9:0] exp_t;

  // job sequencing
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    EXEC
  } ctrl_state_e;

endpackage
